// File: hw/sb2_bus_cfg.svh
/*
 * sb2 bus controller configuration
 * memory map bases, decode masks, RAM depths and clock-enable divisor
 */
`ifndef SB2_BUS_CFG_SVH
`define SB2_BUS_CFG_SVH

// CLK96 cycles per 16 MHz enable
`define SB2_CEN_DIV     6

// byte addresses on the 68000 side
`define SB2_ROM_LIMIT   24'h07FFFF
`define SB2_WRAM_BASE   24'h100000
`define SB2_VDP_BASE    24'h300000
`define SB2_PAL_BASE    24'h400000
`define SB2_IO_BASE     24'h700000

// window masks, bits kept for the base compare
`define SB2_WRAM_MASK   24'hFF0000
`define SB2_VDP_MASK    24'hF00000
`define SB2_PAL_MASK    24'hFFF000
`define SB2_IO_MASK     24'hFFF000

// word address widths
`define SB2_WRAM_AW     15
`define SB2_PAL_AW      11

`endif

// File: hw/sb2_bus_pkg.sv
/*
 * sb2 bus types
 * data word, word address, byte strobes, decoded region and VDP command set
 */
`default_nettype none

package sb2_bus_pkg;

    typedef logic [15:0] bus_word_t;
    typedef logic [22:0] bus_addr_t;   // cpu address bits 23..1
    typedef logic [1:0]  byte_en_t;    // [1] upper, [0] lower

    typedef enum logic [2:0] {
        region_none,
        region_rom,
        region_wram,
        region_vdp,
        region_pal,
        region_io
    } region_e;

    // one bit per VDP command
    typedef struct packed {
        logic select_reg;
        logic write_reg;
        logic write_ram;
        logic read_ram_h;
        logic read_ram_l;
        logic set_ram_ptr;
    } vdp_op_t;

endpackage

`default_nettype wire

// File: hw/sb2_mem_if.sv
/*
 * request/response link between the cycle controller and one bus target
 * req is held with stable fields until done is seen
 */
`default_nettype none

interface sb2_mem_if import sb2_bus_pkg::*; ();

    logic      req;
    bus_addr_t addr;
    logic      we;
    byte_en_t  be;
    bus_word_t wdata;
    bus_word_t rdata;
    logic      done;

    modport master (
        output req, addr, we, be, wdata,
        input  rdata, done
    );

    modport target (
        input  req, addr, we, be, wdata,
        output rdata, done
    );

endinterface

`default_nettype wire

// File: hw/sb2_cen_timer.sv
/*
 * CPU clock enable
 * one CLK96 cycle in every SB2_CEN_DIV, i.e. 16 MHz
 */
`default_nettype none

`include "sb2_bus_cfg.svh"

module sb2_cen_timer (
    input  wire  CLK96,
    input  wire  RESET96,
    output logic cen
);

    localparam int CNT_W = $clog2(`SB2_CEN_DIV);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            cnt <= '0;
            cen <= 1'b0;
        end else begin
            if (cnt == CNT_W'(`SB2_CEN_DIV - 1)) begin
                cnt <= '0;
                cen <= 1'b1;   // one-cycle pulse at wrap
            end else begin
                cnt <= cnt + 1'b1;
                cen <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/sb2_cycle_fsm.sv
/*
 * 68000 bus cycle controller
 * decodes the address, runs the ROM port or one target request,
 * latches read data and returns a single-cycle dtack
 */
`default_nettype none

`include "sb2_bus_cfg.svh"

module sb2_cycle_fsm import sb2_bus_pkg::*; (
    input  wire               CLK96,
    input  wire               RESET96,
    input  wire               cen,
    input  wire               cpu_as,
    input  wire bus_addr_t    cpu_addr,
    input  wire               cpu_rw,
    input  wire byte_en_t     cpu_ds,
    input  wire bus_word_t    cpu_wdata,
    output bus_word_t         cpu_rdata,
    output logic              cpu_dtack,
    output logic              prg_cs,
    output logic [18:0]       prg_addr,
    input  wire               prg_ok,
    input  wire bus_word_t    prg_data,
    sb2_mem_if.master         wram,
    sb2_mem_if.master         pal,
    sb2_mem_if.master         io,
    sb2_mem_if.master         vdp
);

    typedef enum logic [2:0] {
        st_idle,
        st_decode,
        st_wait,
        st_ack,
        st_release
    } state_e;

    state_e    state;
    region_e   region_q;
    logic      req_q;
    bus_addr_t addr_q;
    logic      we_q;
    byte_en_t  be_q;
    bus_word_t wdata_q;
    logic      sel_done;
    bus_word_t sel_rdata;

    function automatic region_e decode_region(input bus_addr_t a);
        logic [23:0] ba;
        ba = {a, 1'b0};
        if (ba <= `SB2_ROM_LIMIT)
            return region_rom;
        if ((ba & `SB2_WRAM_MASK) == `SB2_WRAM_BASE)
            return region_wram;
        if ((ba & `SB2_VDP_MASK) == `SB2_VDP_BASE)
            return region_vdp;
        if ((ba & `SB2_PAL_MASK) == `SB2_PAL_BASE)
            return region_pal;
        if ((ba & `SB2_IO_MASK) == `SB2_IO_BASE)
            return region_io;
        return region_none;
    endfunction

    // cycle fields, captured once per strobe
    always_ff @(posedge CLK96) begin
        if (state == st_idle && cen && cpu_as) begin
            addr_q  <= cpu_addr;
            we_q    <= !cpu_rw;   // 68k rw high = read
            be_q    <= cpu_ds;
            wdata_q <= cpu_wdata;
        end
    end

    assign prg_addr = addr_q[18:0];

    // same fields to every target, req only to the decoded one
    assign wram.req   = req_q && (region_q == region_wram);
    assign wram.addr  = addr_q;
    assign wram.we    = we_q;
    assign wram.be    = be_q;
    assign wram.wdata = wdata_q;

    assign pal.req   = req_q && (region_q == region_pal);
    assign pal.addr  = addr_q;
    assign pal.we    = we_q;
    assign pal.be    = be_q;
    assign pal.wdata = wdata_q;

    assign io.req   = req_q && (region_q == region_io);
    assign io.addr  = addr_q;
    assign io.we    = we_q;
    assign io.be    = be_q;
    assign io.wdata = wdata_q;

    assign vdp.req   = req_q && (region_q == region_vdp);
    assign vdp.addr  = addr_q;
    assign vdp.we    = we_q;
    assign vdp.be    = be_q;
    assign vdp.wdata = wdata_q;

    always_comb begin
        case (region_q)
            region_wram: begin
                sel_done  = wram.done;
                sel_rdata = wram.rdata;
            end
            region_pal: begin
                sel_done  = pal.done;
                sel_rdata = pal.rdata;
            end
            region_io: begin
                sel_done  = io.done;
                sel_rdata = io.rdata;
            end
            region_vdp: begin
                sel_done  = vdp.done;
                sel_rdata = vdp.rdata;
            end
            default: begin
                sel_done  = 1'b0;
                sel_rdata = '0;
            end
        endcase
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state     <= st_idle;
            region_q  <= region_none;
            req_q     <= 1'b0;
            prg_cs    <= 1'b0;
            cpu_dtack <= 1'b0;
            cpu_rdata <= '0;
        end else begin
            cpu_dtack <= 1'b0;
            case (state)
                st_idle: begin
                    if (cen && cpu_as) begin   // strobe only seen on the enable
                        region_q <= decode_region(cpu_addr);
                        state    <= st_decode;
                    end
                end
                st_decode: begin
                    case (region_q)
                        region_rom: begin
                            if (we_q) begin
                                state <= st_ack;   // ROM writes dropped
                            end else begin
                                prg_cs <= 1'b1;
                                state  <= st_wait;
                            end
                        end
                        region_none: begin
                            if (!we_q)
                                cpu_rdata <= '0;   // open bus reads zero
                            state <= st_ack;
                        end
                        default: begin
                            req_q <= 1'b1;
                            state <= st_wait;
                        end
                    endcase
                end
                st_wait: begin
                    if (region_q == region_rom) begin
                        if (prg_ok) begin   // no limit on ROM latency
                            prg_cs    <= 1'b0;
                            cpu_rdata <= prg_data;
                            state     <= st_ack;
                        end
                    end else if (sel_done) begin
                        req_q <= 1'b0;
                        if (!we_q)
                            cpu_rdata <= sel_rdata;
                        state <= st_ack;
                    end
                end
                st_ack: begin
                    cpu_dtack <= 1'b1;
                    state     <= st_release;
                end
                st_release: begin
                    if (cen && !cpu_as)
                        state <= st_idle;   // next cycle needs a fresh strobe
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/sb2_dual_ram.sv
/*
 * dual-port 16-bit RAM
 * byte writes and reads on the bus port, registered read-only second port
 */
`default_nettype none

module sb2_dual_ram import sb2_bus_pkg::*; #(
    parameter int ADDR_W = 15
) (
    input  wire               CLK96,
    sb2_mem_if.target         port,
    input  wire [ADDR_W-1:0]  rd_addr,
    output bus_word_t         rd_data
);

    localparam int DEPTH = 2 ** ADDR_W;

    bus_word_t         mem [DEPTH];
    logic [ADDR_W-1:0] bus_addr;

    assign bus_addr = port.addr[ADDR_W-1:0];   // window offset only

    always_ff @(posedge CLK96) begin
        port.done <= port.req && !port.done;   // done one cycle after req
        if (port.req && !port.done) begin
            if (port.we && port.be[1])
                mem[bus_addr][15:8] <= port.wdata[15:8];
            if (port.we && port.be[0])
                mem[bus_addr][7:0] <= port.wdata[7:0];
            port.rdata <= mem[bus_addr];
        end
        rd_data <= mem[rd_addr];   // video side
    end

endmodule

`default_nettype wire

// File: hw/sb2_io_ports.sv
/*
 * cabinet input and DIP switch read ports
 * active-low cabinet inputs are inverted into the game's format
 */
`default_nettype none

module sb2_io_ports import sb2_bus_pkg::*; (
    input  wire        CLK96,
    input  wire        RESET96,
    sb2_mem_if.target  port,
    input  wire [9:0]  joy1,
    input  wire [9:0]  joy2,
    input  wire [1:0]  start_button,
    input  wire [1:0]  coin,
    input  wire        service,
    input  wire        dip_test,
    input  wire [7:0]  dipsw_a,
    input  wire [7:0]  dipsw_b,
    input  wire [7:0]  dipsw_c
);

    logic [11:0] offset;
    logic [7:0]  p1_byte;
    logic [7:0]  p2_byte;
    logic [7:0]  sys_byte;
    bus_word_t   read_word;

    assign offset = {port.addr[10:0], 1'b0};

    // up, down, right, left order for the game
    assign p1_byte = {2'b00, ~joy1[5], ~joy1[4], ~joy1[0], ~joy1[1], ~joy1[2], ~joy1[3]};
    assign p2_byte = {2'b00, ~joy2[5], ~joy2[4], ~joy2[0], ~joy2[1], ~joy2[2], ~joy2[3]};
    assign sys_byte = {1'b0, ~start_button[1], ~start_button[0], ~coin[1], ~coin[0],
                       ~dip_test, 1'b0, ~service};

    always_comb begin
        case (offset)
            12'h000: read_word = {2{dipsw_c}};
            12'h004: read_word = {2{dipsw_a}};
            12'h008: read_word = {2{dipsw_b}};
            12'h00C: read_word = {2{p1_byte}};
            12'h010: read_word = {2{p2_byte}};
            12'h01C: read_word = {dipsw_c, sys_byte};
            default: read_word = '0;
        endcase
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            port.done  <= 1'b0;
            port.rdata <= '0;
        end else begin
            port.done <= port.req && !port.done;
            if (port.req && !port.done)
                port.rdata <= port.we ? '0 : read_word;   // coin word writes land here too
        end
    end

endmodule

`default_nettype wire

// File: hw/sb2_vdp_cmd.sv
/*
 * VDP command strobes
 * one strobe per access, held until the VDP acknowledges
 */
`default_nettype none

module sb2_vdp_cmd import sb2_bus_pkg::*; (
    input  wire             CLK96,
    input  wire             RESET96,
    sb2_mem_if.target       port,
    output vdp_op_t         vdp_op,
    input  wire             vdp_ack,
    input  wire bus_word_t  vdp_data
);

    logic [3:0] offset;
    vdp_op_t    op_next;
    logic       issue;
    logic       ack_hit;
    logic       quick_done;   // offsets with no command

    assign offset  = {port.addr[2:0], 1'b0};
    assign issue   = port.req && !port.done && (vdp_op == '0);
    assign ack_hit = vdp_ack && (vdp_op != '0);

    always_comb begin
        op_next = '0;
        if (port.we) begin
            case (offset)
                4'h0:       op_next.set_ram_ptr = 1'b1;
                4'h4, 4'h6: op_next.write_ram   = 1'b1;
                4'h8:       op_next.select_reg  = 1'b1;
                4'hC:       op_next.write_reg   = 1'b1;
                default:    op_next = '0;
            endcase
        end else begin
            case (offset)
                4'h4:    op_next.read_ram_h = 1'b1;
                4'h6:    op_next.read_ram_l = 1'b1;
                default: op_next = '0;
            endcase
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            vdp_op     <= '0;
            quick_done <= 1'b0;
        end else begin
            quick_done <= 1'b0;
            if (ack_hit)
                vdp_op <= '0;   // VDP took it
            else if (issue) begin
                if (op_next == '0)
                    quick_done <= 1'b1;
                else
                    vdp_op <= op_next;
            end
        end
    end

    assign port.done  = quick_done || ack_hit;
    assign port.rdata = ack_hit ? vdp_data : '0;

endmodule

`default_nettype wire

// File: hw/sb2_bus.sv
/*
 * main CPU bus controller
 * clock enable, cycle controller, work RAM, palette RAM, I/O ports and VDP strobes
 */
`default_nettype none

`include "sb2_bus_cfg.svh"

module sb2_bus import sb2_bus_pkg::*; (
    input  wire                     CLK96,
    input  wire                     RESET96,
    output logic                    cpu_cen,
    // 68000 side
    input  wire                     cpu_as,
    input  wire bus_addr_t          cpu_addr,
    input  wire                     cpu_rw,
    input  wire byte_en_t           cpu_ds,
    input  wire bus_word_t          cpu_wdata,
    output bus_word_t               cpu_rdata,
    output logic                    cpu_dtack,
    // program ROM
    output logic                    prg_cs,
    output logic [18:0]             prg_addr,
    input  wire                     prg_ok,
    input  wire bus_word_t          prg_data,
    // cabinet
    input  wire [9:0]               joy1,
    input  wire [9:0]               joy2,
    input  wire [1:0]               start_button,
    input  wire [1:0]               coin,
    input  wire                     service,
    input  wire                     dip_test,
    input  wire [7:0]               dipsw_a,
    input  wire [7:0]               dipsw_b,
    input  wire [7:0]               dipsw_c,
    // VDP
    output logic                    vdp_select_reg,
    output logic                    vdp_write_reg,
    output logic                    vdp_write_ram,
    output logic                    vdp_read_ram_h,
    output logic                    vdp_read_ram_l,
    output logic                    vdp_set_ram_ptr,
    input  wire                     vdp_ack,
    input  wire bus_word_t          vdp_data,
    // palette read for video
    input  wire [`SB2_PAL_AW-1:0]   pal_addr,
    output bus_word_t               pal_data
);

    sb2_mem_if wram_bus ();
    sb2_mem_if pal_bus ();
    sb2_mem_if io_bus ();
    sb2_mem_if vdp_bus ();

    vdp_op_t vdp_op;

    sb2_cen_timer u_cen (
        .CLK96   (CLK96),
        .RESET96 (RESET96),
        .cen     (cpu_cen)
    );

    sb2_cycle_fsm u_fsm (
        .CLK96     (CLK96),
        .RESET96   (RESET96),
        .cen       (cpu_cen),
        .cpu_as    (cpu_as),
        .cpu_addr  (cpu_addr),
        .cpu_rw    (cpu_rw),
        .cpu_ds    (cpu_ds),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .cpu_dtack (cpu_dtack),
        .prg_cs    (prg_cs),
        .prg_addr  (prg_addr),
        .prg_ok    (prg_ok),
        .prg_data  (prg_data),
        .wram      (wram_bus.master),
        .pal       (pal_bus.master),
        .io        (io_bus.master),
        .vdp       (vdp_bus.master)
    );

    // 0x100000 work RAM, video port not used
    sb2_dual_ram #(.ADDR_W(`SB2_WRAM_AW)) u_wram (
        .CLK96   (CLK96),
        .port    (wram_bus.target),
        .rd_addr ('0),
        .rd_data ()
    );

    // 0x400000 palette RAM
    sb2_dual_ram #(.ADDR_W(`SB2_PAL_AW)) u_pal (
        .CLK96   (CLK96),
        .port    (pal_bus.target),
        .rd_addr (pal_addr),
        .rd_data (pal_data)
    );

    sb2_io_ports u_io (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .port         (io_bus.target),
        .joy1         (joy1),
        .joy2         (joy2),
        .start_button (start_button),
        .coin         (coin),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c)
    );

    sb2_vdp_cmd u_vdp (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .port     (vdp_bus.target),
        .vdp_op   (vdp_op),
        .vdp_ack  (vdp_ack),
        .vdp_data (vdp_data)
    );

    assign vdp_select_reg  = vdp_op.select_reg;
    assign vdp_write_reg   = vdp_op.write_reg;
    assign vdp_write_ram   = vdp_op.write_ram;
    assign vdp_read_ram_h  = vdp_op.read_ram_h;
    assign vdp_read_ram_l  = vdp_op.read_ram_l;
    assign vdp_set_ram_ptr = vdp_op.set_ram_ptr;

endmodule

`default_nettype wire

// File: testbench/sb2_bus_sva.sv
/*
 * bus protocol assertions for the sb2 bus controller
 * single-cycle dtack, ROM select inside a strobe, one VDP command at a time
 */
`default_nettype none

module sb2_bus_sva (
    input wire       CLK96,
    input wire       RESET96,
    input wire       cpu_as,
    input wire       cpu_dtack,
    input wire       prg_cs,
    input wire [5:0] vdp_strobes
);

    int unsigned fails = 0;   // read by the testbench

    dtack_single: assert property (@(posedge CLK96) disable iff (RESET96)
        cpu_dtack |=> !cpu_dtack)
        else begin
            $error("cpu_dtack high for more than one cycle");
            fails++;
        end

    // ROM is only selected inside a CPU cycle
    prg_inside_as: assert property (@(posedge CLK96) disable iff (RESET96)
        prg_cs |-> cpu_as)
        else begin
            $error("prg_cs high while cpu_as is low");
            fails++;
        end

    vdp_onehot: assert property (@(posedge CLK96) disable iff (RESET96)
        $onehot0(vdp_strobes))
        else begin
            $error("more than one VDP command strobe high");
            fails++;
        end

endmodule

bind sb2_bus sb2_bus_sva u_sva (
    .CLK96       (CLK96),
    .RESET96     (RESET96),
    .cpu_as      (cpu_as),
    .cpu_dtack   (cpu_dtack),
    .prg_cs      (prg_cs),
    .vdp_strobes ({vdp_select_reg, vdp_write_reg, vdp_write_ram,
                   vdp_read_ram_h, vdp_read_ram_l, vdp_set_ram_ptr})
);

`default_nettype wire

// File: testbench/tb_sb2_bus.sv
/*
 * testbench for the sb2 bus controller
 * file-driven CPU accesses, ROM and VDP models answering after random delays
 */
`default_nettype none

`include "sb2_bus_cfg.svh"

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // period 40
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

module tb_sb2_bus import sb2_bus_pkg::*; ();

    localparam string STIM_FILE = "testbench/sb2_bus_input.txt";

    logic CLK96, RESET96, cpu_cen;
    logic cpu_as, cpu_rw, cpu_dtack, prg_cs, prg_ok;
    bus_addr_t cpu_addr;
    byte_en_t  cpu_ds;
    bus_word_t cpu_wdata, cpu_rdata, prg_data, vdp_data, pal_data;
    logic [18:0] prg_addr;
    logic [9:0]  joy1, joy2;
    logic [1:0]  start_button, coin;
    logic        service, dip_test;
    logic [7:0]  dipsw_a, dipsw_b, dipsw_c;
    logic        vdp_select_reg, vdp_write_reg, vdp_write_ram;
    logic        vdp_read_ram_h, vdp_read_ram_l, vdp_set_ram_ptr, vdp_ack;
    logic [10:0] pal_addr;
    vdp_op_t     vdp_bits;

    // stimulus table, one entry per file line
    string       t_name[$], t_op[$];
    logic [23:0] t_addr[$], t_dip[$];
    logic [31:0] t_joy[$];
    byte_en_t    t_be[$];
    bus_word_t   t_wdata[$], t_exp[$];

    int unsigned rand_tab [256];
    logic [7:0]  hold_idx = 8'd170;
    int unsigned errors = 0;
    int unsigned vdp_errs = 0;
    int unsigned failed = 0;
    int unsigned cycles = 0;
    int unsigned cycle_limit = 0;
    int unsigned cen_gap = 0;
    int unsigned vdp_op_count = 0;
    vdp_op_t     vdp_last_op;
    bus_word_t   vdp_resp;
    string       cur_name = "reset";

    tb_clock u_clk (.clk(CLK96), .rst(RESET96));

    sb2_bus dut0 (.*);

    assign vdp_bits = {vdp_select_reg, vdp_write_reg, vdp_write_ram,
                       vdp_read_ram_h, vdp_read_ram_l, vdp_set_ram_ptr};

    function automatic int unsigned total_errors();
        return errors + vdp_errs + dut0.u_sva.fails;
    endfunction

    // VDP command table of the memory map
    function automatic vdp_op_t expected_op(input logic [23:0] addr, input logic write);
        vdp_op_t op;
        op = '0;
        if ((addr & `SB2_VDP_MASK) == `SB2_VDP_BASE) begin
            if (write) begin
                case (addr[3:0])
                    4'h0:       op.set_ram_ptr = 1'b1;
                    4'h4, 4'h6: op.write_ram = 1'b1;
                    4'h8:       op.select_reg = 1'b1;
                    4'hC:       op.write_reg = 1'b1;
                    default:    op = '0;
                endcase
            end else if (addr[3:0] == 4'h4) begin
                op.read_ram_h = 1'b1;
            end else if (addr[3:0] == 4'h6) begin
                op.read_ram_l = 1'b1;
            end
        end
        return op;
    endfunction

    task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %04h actual %04h", name, exp, act);
        end
    endtask

    task automatic check_vdp_op(input string name, input vdp_op_t exp, input vdp_op_t act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %06b actual %06b", name, exp, act);
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          cnt;
        string       line, name, op;
        logic [23:0] addr, dip;
        logic [31:0] joy;
        byte_en_t    be;
        bus_word_t   wdata, expv;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    cnt = $sscanf(line, "%s %s %h %h %h %h %h %h",
                                  name, op, addr, be, wdata, joy, dip, expv);
                    if (cnt == 8) begin
                        t_name.push_back(name);
                        t_op.push_back(op);
                        t_addr.push_back(addr);
                        t_be.push_back(be);
                        t_wdata.push_back(wdata);
                        t_joy.push_back(joy);
                        t_dip.push_back(dip);
                        t_exp.push_back(expv);
                    end else begin
                        errors++;
                        $display("malformed stimulus line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // joy = {start, coin, 2'b0, service, dip_test, joy2[11:0], joy1[11:0]}
    task automatic apply_cabinet(input logic [31:0] joy, input logic [23:0] dip);
        @(posedge CLK96);
        start_button <= joy[31:30];
        coin         <= joy[29:28];
        service      <= joy[25];
        dip_test     <= joy[24];
        joy2         <= joy[21:12];
        joy1         <= joy[9:0];
        dipsw_c      <= dip[23:16];
        dipsw_b      <= dip[15:8];
        dipsw_a      <= dip[7:0];
    endtask

    task automatic cpu_access(input logic [23:0] addr, input logic write, input byte_en_t be,
                              input bus_word_t wdata, output bus_word_t rdata);
        int unsigned hold_n;
        @(negedge CLK96);
        while (!cpu_cen)
            @(negedge CLK96);
        @(posedge CLK96);
        cpu_addr  <= addr[23:1];
        cpu_rw    <= !write;
        cpu_ds    <= be;
        cpu_wdata <= wdata;
        cpu_as    <= 1'b1;
        @(negedge CLK96);
        while (!cpu_dtack)
            @(negedge CLK96);
        rdata  = cpu_rdata;
        // strobe stays up over several enables, long enough for a whole second cycle
        hold_n = 5 * `SB2_CEN_DIV + rand_tab[hold_idx];
        hold_idx++;
        repeat (hold_n) begin
            @(negedge CLK96);
            if (cpu_dtack) begin
                errors++;
                $display("test %s: second dtack while cpu_as still high", cur_name);
            end
        end
        @(posedge CLK96);
        cpu_as <= 1'b0;
    endtask

    task automatic run_tests();
        bus_word_t   rdata;
        vdp_op_t     seen;
        int unsigned count_before;
        int unsigned errs_before;
        logic        write;
        for (int i = 0; i < t_name.size(); i++) begin
            errs_before  = total_errors();
            count_before = vdp_op_count;
            cur_name     = t_name[i];
            vdp_resp     = t_wdata[i];   // VDP reply on reads
            write        = (t_op[i] == "write") || (t_op[i] == "pal");
            if (t_op[i] == "io") begin
                apply_cabinet(t_joy[i], t_dip[i]);
            end else if (!write && t_op[i] != "read") begin
                errors++;
                $display("test %s: unknown operation %s", t_name[i], t_op[i]);
            end
            cpu_access(t_addr[i], write, t_be[i], t_wdata[i], rdata);
            if (!write)
                check_word(t_name[i], t_exp[i], rdata);
            if (t_op[i] == "pal") begin
                @(posedge CLK96);
                pal_addr <= t_addr[i][11:1];
                @(posedge CLK96);   // video port registers here
                @(negedge CLK96);
                check_word(t_name[i], t_exp[i], pal_data);
            end
            seen = '0;
            if (vdp_op_count != count_before)
                seen = vdp_last_op;
            check_vdp_op(t_name[i], expected_op(t_addr[i], write), seen);
            if (total_errors() == errs_before) begin
                $display("test %-10s ok", t_name[i]);
            end else begin
                failed++;
                $display("test %-10s failed", t_name[i]);
            end
        end
    endtask

    // program ROM, data is the word address xor 5A5A
    initial begin : rom_model
        logic [7:0] idx;
        prg_ok   = 1'b0;
        prg_data = '0;
        idx      = 8'd0;
        forever begin
            @(negedge CLK96);
            if (prg_cs === 1'b1) begin
                repeat (rand_tab[idx]) @(posedge CLK96);
                idx++;
                @(posedge CLK96);
                prg_data <= prg_addr[15:0] ^ 16'h5A5A;
                prg_ok   <= 1'b1;
                @(posedge CLK96);
                prg_ok   <= 1'b0;
            end
        end
    end

    initial begin : vdp_model
        vdp_op_t    op;
        logic [7:0] idx;
        vdp_ack  = 1'b0;
        vdp_data = '0;
        idx      = 8'd85;
        forever begin
            @(negedge CLK96);
            op = vdp_bits;
            if (op != '0) begin
                vdp_last_op  = op;
                vdp_op_count = vdp_op_count + 1;
                repeat (rand_tab[idx]) begin
                    @(negedge CLK96);
                    if (vdp_bits !== op) begin
                        vdp_errs = vdp_errs + 1;
                        $display("test %s: VDP strobe changed before vdp_ack", cur_name);
                    end
                end
                idx++;
                @(posedge CLK96);
                vdp_data <= vdp_resp;
                vdp_ack  <= 1'b1;
                @(posedge CLK96);
                vdp_ack  <= 1'b0;
            end
        end
    end

    // enable pulse returns exactly SB2_CEN_DIV cycles after the previous one
    always @(negedge CLK96) begin
        if (RESET96) begin
            cen_gap <= 0;
        end else if (cpu_cen) begin
            if (cen_gap != 0 && cen_gap != `SB2_CEN_DIV) begin
                errors++;
                $display("ERR %s cpu_cen period expected %0d actual %0d", cur_name,
                         `SB2_CEN_DIV, cen_gap);
            end
            cen_gap <= 1;
        end else if (cen_gap != 0) begin
            cen_gap <= cen_gap + 1;
        end
    end

    always @(posedge CLK96) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, a bus cycle never completed", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin : main
        void'($urandom(60923));
        for (int k = 0; k < 256; k++)
            rand_tab[k] = $urandom % 8;   // delays 0..7 cycles
        cpu_as       = 1'b0;
        cpu_rw       = 1'b1;
        cpu_addr     = '0;
        cpu_ds       = '0;
        cpu_wdata    = '0;
        joy1         = '0;
        joy2         = '0;
        start_button = '0;
        coin         = '0;
        service      = 1'b0;
        dip_test     = 1'b0;
        dipsw_a      = '0;
        dipsw_b      = '0;
        dipsw_c      = '0;
        pal_addr     = '0;
        vdp_resp     = '0;
        load_tests();
        cycle_limit = t_name.size() * 400;
        if (t_name.size() == 0) begin
            $display("no tests loaded, nothing was checked");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            @(negedge CLK96);
            while (RESET96)
                @(negedge CLK96);
            run_tests();
            $display("tests %0d, failed %0d, errors %0d", t_name.size(), failed,
                     total_errors());
            if (failed == 0 && total_errors() == 0)
                $display("RESULT: PASS");
            else
                $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sb2_bus.f
+incdir+hw
hw/sb2_bus_pkg.sv
hw/sb2_mem_if.sv
hw/sb2_cen_timer.sv
hw/sb2_cycle_fsm.sv
hw/sb2_dual_ram.sv
hw/sb2_io_ports.sv
hw/sb2_vdp_cmd.sv
hw/sb2_bus.sv
testbench/sb2_bus_sva.sv
testbench/tb_sb2_bus.sv

// File: Bender.yml
package:
  name: sb2_bus

sources:
  - include_dirs:
      - hw
    files:
      - hw/sb2_bus_pkg.sv
      - hw/sb2_mem_if.sv
      - hw/sb2_cen_timer.sv
      - hw/sb2_cycle_fsm.sv
      - hw/sb2_dual_ram.sv
      - hw/sb2_io_ports.sv
      - hw/sb2_vdp_cmd.sv
      - hw/sb2_bus.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/sb2_bus_sva.sv
      - testbench/tb_sb2_bus.sv

// File: testbench/sb2_bus_input.txt
# name op byte_addr be wdata joy dip expected (hex), wdata is the VDP reply on VDP reads
# joy = {start,coin,00,service,dip_test,joy2[11:0],joy1[11:0]}  dip = {c,b,a}
rom_zero read 000000 3 0000 0 0 5A5A
rom_mid read 001234 3 0000 0 0 5340
rom_high read 04ABCE 3 0000 0 0 0FBD
rom_last read 07FFFE 3 0000 0 0 A5A5
wr_both write 100010 3 FFFF 0 0 0000
wr_upper write 100010 2 1234 0 0 0000
rd_upper read 100010 3 0000 0 0 12FF
wr_lower write 100010 1 ABCD 0 0 0000
wr_none write 100010 0 5555 0 0 0000
rd_lower read 100010 3 0000 0 0 12CD
wr_top write 10FFFE 3 A55A 0 0 0000
rd_top read 10FFFE 3 0000 0 0 A55A
rd_keep read 100010 3 0000 0 0 12CD
pal_both pal 400246 3 0F0F 0 0 0F0F
pal_upper pal 400246 2 7700 0 0 770F
pal_cpu read 400246 3 0000 0 0 770F
io_dipc io 700000 3 0000 6200A035 5AC381 5A5A
io_dipa io 700004 3 0000 6200A035 5AC381 8181
io_dipb io 700008 3 0000 6200A035 5AC381 C3C3
io_p1 io 70000C 3 0000 6200A035 5AC381 0505
io_p2 io 700010 3 0000 6200A035 5AC381 3A3A
io_sys io 70001C 3 0000 6200A035 5AC381 5A4C
io_gap io 700014 3 0000 6200A035 5AC381 0000
io_coin write 700034 3 0003 0 0 0000
open_lo read 200000 3 0000 0 0 0000
open_hi read 500000 3 0000 0 0 0000
vdp_rd_h read 300004 3 BEEF 0 0 BEEF
vdp_rd_l read 300006 3 1357 0 0 1357
vdp_ptr write 300000 3 4000 0 0 0000
vdp_ram4 write 300004 3 0123 0 0 0000
vdp_ram6 write 300006 3 4567 0 0 0000
vdp_sel write 300008 3 8F02 0 0 0000
vdp_reg write 30000C 3 0001 0 0 0000
vdp_gap read 300002 3 CAFE 0 0 0000
